// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_ppu
FILELIST  = ppu.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// ==== bench/tb_ppu.sv ====
module tb_ppu import ppu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_DIV     = 4;
    localparam int LINE_DOTS   = 341;
    localparam int FRAME_DOTS  = 341 * 262;
    localparam int LOAD_WRITES = 8192 + 2048 + 32 + 1;
    localparam int CYCLE_LIMIT = 8 + LOAD_WRITES + 5 * FRAME_DOTS * CLK_DIV
                                 + 4 * LINE_DOTS * CLK_DIV;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       cpu_we;
    logic [13:0] cpu_addr;
    logic [7:0] cpu_wdata;
    logic       vblank;
    logic       vsync_n;
    logic       hsync_n;
    logic [2:0] vga_r;
    logic [2:0] vga_g;
    logic [1:0] vga_b;

    // Reference copies of the PPU memories
    logic [7:0] m_chr  [8192];
    logic [7:0] m_vram [2048];
    logic [7:0] m_pal  [32];
    logic [7:0] m_ctrl;

    integer      seed;
    int          cycles = 0;
    int          mrow;      // Position shown on the pins
    int          mcol;
    int          vb_len;    // Dots of the measured vblank run
    int          vb_rises;
    logic        vb_prev;
    logic [21:0] upd_q [$]; // {addr, data} rewrites for the blank

    ppu #(.CLK_DIV(CLK_DIV)) i_dut (
        .clk,
        .rst_n,
        .cpu_we,
        .cpu_addr,
        .cpu_wdata,
        .vblank,
        .vsync_n,
        .hsync_n,
        .vga_r,
        .vga_g,
        .vga_b
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Something failed");
            $fatal(1);
        end
    end

    function automatic logic [7:0] rand_byte();
        return 8'($random(seed));
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h at row %0d col %0d",
                     name, got, exp, mrow, mcol);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic model_write(input logic [13:0] addr, input logic [7:0] data);
        if (addr < 14'h2000) begin
            m_chr[addr[12:0]] = data;
        end else if (addr < 14'h2800) begin
            m_vram[addr[10:0]] = data;
        end else if (addr == 14'h3000) begin
            m_ctrl = data;
        end else if (addr >= 14'h3F00 && addr <= 14'h3F1F) begin
            m_pal[addr[4:0]] = data;
        end
    endtask

    // Single write strobe of one clock
    task automatic cpu_write(input logic [13:0] addr, input logic [7:0] data);
        model_write(addr, data);
        cpu_we    = 1'b1;
        cpu_addr  = addr;
        cpu_wdata = data;
        @(posedge clk);
        #1;
        cpu_we = 1'b0;
    endtask

    function automatic logic [7:0] expect_color(input int r, input int c);
        logic [7:0] tile;
        logic [7:0] lo;
        logic [7:0] hi;
        logic [2:0] b;
        logic [1:0] pix;
        logic [4:0] idx;
        if (r >= 240 || c >= 256 || !m_ctrl[CTRL_REN]) begin
            return 8'h00;
        end
        tile = m_vram[{m_ctrl[CTRL_NT], 5'(r / 8), 5'(c / 8)}];
        lo   = m_chr[{m_ctrl[CTRL_PT], tile, 1'b0, 3'(r % 8)}];
        hi   = m_chr[{m_ctrl[CTRL_PT], tile, 1'b1, 3'(r % 8)}];
        b    = 3'(7 - c % 8);  // Leftmost dot in bit 7
        pix  = {hi[b], lo[b]};
        idx  = (pix == 2'b00) ? 5'd0 : {1'b0, m_ctrl[CTRL_PAL +: 2], pix};
        return m_pal[idx];
    endfunction

    function automatic logic expect_vblank(input int r, input int c);
        int ur;
        ur = ((r * LINE_DOTS + c + 4) % FRAME_DOTS) / LINE_DOTS;  // Counters run 4 dots ahead
        return m_ctrl[CTRL_NMI] && ur >= 241 && ur <= 260;
    endfunction

    task automatic check_dot();
        check_val("color", 32'({vga_r, vga_g, vga_b}), 32'(expect_color(mrow, mcol)));
        check_val("hsync_n", 32'(hsync_n), 32'(!(mcol >= 280 && mcol <= 303)));
        check_val("vsync_n", 32'(vsync_n), 32'(!(mrow >= 245 && mrow <= 247)));
        check_val("vblank", 32'(vblank), 32'(expect_vblank(mrow, mcol)));
        if (vblank && !vb_prev) begin
            vb_rises++;
            vb_len = 1;
        end else if (vblank && vb_len > 0) begin
            vb_len++;
        end else if (!vblank && vb_prev && vb_len > 0 && m_ctrl[CTRL_NMI]) begin
            check_val("vblank_len", 32'(vb_len), 32'(20 * LINE_DOTS));
        end
        vb_prev = vblank;
    endtask

    // Pin position (245, 0) is the first dot of the vsync pulse
    task automatic align_raster();
        @(negedge vsync_n);
        #1;
        mrow    = 245;
        mcol    = 0;
        vb_prev = vblank;
        vb_len  = 0;
    endtask

    task automatic check_frame(input bit updates, input int exp_rises);
        logic [21:0] entry;
        vb_rises = 0;
        for (int i = 0; i < FRAME_DOTS; i++) begin
            check_dot();
            if (updates && mrow >= 246 && mrow < 256 && upd_q.size() > 0) begin
                entry = upd_q.pop_front();
                cpu_write(entry[21:8], entry[7:0]);
                wait_clocks(CLK_DIV - 1);
            end else if (updates && mrow == 261 && mcol == 0) begin
                cpu_write(CTRL_ADDR, m_ctrl & 8'h7F);  // Interrupt off after the blank
                wait_clocks(CLK_DIV - 1);
            end else begin
                wait_clocks(CLK_DIV);
            end
            mcol++;
            if (mcol == LINE_DOTS) begin
                mcol = 0;
                mrow = (mrow + 1) % 262;
            end
        end
        check_val("vblank_rises", 32'(vb_rises), 32'(exp_rises));
    endtask

    initial begin
        seed      = 54;
        rst_n     = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        m_ctrl    = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int a = 0; a < 8192; a++) begin
            cpu_write(CHR_BASE + 14'(a), rand_byte());
        end
        for (int a = 0; a < 2048; a++) begin
            cpu_write(VRAM_BASE + 14'(a), rand_byte());
        end
        for (int a = 0; a < 32; a++) begin
            cpu_write(PAL_BASE + 14'(a), rand_byte());
        end

        // Picture data in place while the control register is still 0
        align_raster();
        check_frame(1'b0, 0);

        cpu_write(CTRL_ADDR, 8'h90 | (rand_byte() & 8'h0F));  // Render and NMI on
        align_raster();
        check_frame(1'b0, 1);

        // Rewrites aimed at the table shown next frame
        for (int i = 0; i < 64; i++) begin
            upd_q.push_back({VRAM_BASE | 14'({~m_ctrl[CTRL_NT], 10'($random(seed))}),
                             rand_byte()});
        end
        for (int i = 0; i < 8; i++) begin
            upd_q.push_back({PAL_BASE | 14'(5'($random(seed))), rand_byte()});
        end
        upd_q.push_back({CTRL_ADDR, m_ctrl ^ 8'h0F});  // Flip both tables and palette
        check_frame(1'b1, 0);

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== ppu.f ====
rtl/ppu_pkg.sv
rtl/scan_if.sv
rtl/render_mem_if.sv
rtl/clock_div.sv
rtl/ppu_timing.sv
rtl/ppu_mem.sv
rtl/bg_pixel.sv
rtl/ppu.sv
bench/tb_ppu.sv

// ==== rtl/bg_pixel.sv ====
module bg_pixel import ppu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         dot_en,
    scan_if.pixel        scan,
    render_mem_if.fetch  mem,
    input  logic         nt_sel,
    input  logic         pt_sel,
    input  logic [1:0]   bg_pal,
    input  logic         render_en,
    output color_t       color,
    output logic         hsync_n,
    output logic         vsync_n
);

    // Per-stage flags, index 0 is the newest position
    logic [PIPE_DEPTH-1:0] act_d;
    logic [PIPE_DEPTH-1:0] hs_d;
    logic [PIPE_DEPTH-1:0] vs_d;

    logic [2:0] fine_row_s1;
    logic [2:0] fine_col_s1;
    logic [2:0] fine_col_s2;
    logic [1:0] pix;

    // Stage 1 address, tile lookup
    assign mem.vram_addr = {nt_sel, scan.row[7:3], scan.col[7:3]};

    // Stage 2 addresses, both planes of the fetched tile
    assign mem.chr_addr0 = {pt_sel, mem.vram_data, 1'b0, fine_row_s1};
    assign mem.chr_addr1 = {pt_sel, mem.vram_data, 1'b1, fine_row_s1};

    // Stage 3 address, leftmost pixel is bit 7
    assign pix = {mem.chr_data1[3'd7 - fine_col_s2], mem.chr_data0[3'd7 - fine_col_s2]};
    assign mem.pal_addr = (pix == 2'b00) ? '0 : {1'b0, bg_pal, pix};  // 0 is backdrop

    always_ff @(posedge clk) begin
        if (dot_en) begin
            fine_row_s1 <= scan.row[2:0];
            fine_col_s1 <= scan.col[2:0];
            fine_col_s2 <= fine_col_s1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_d <= '0;
            hs_d  <= '1;
            vs_d  <= '1;
        end else if (dot_en) begin
            act_d <= {act_d[PIPE_DEPTH-2:0], scan.active};
            hs_d  <= {hs_d[PIPE_DEPTH-2:0], scan.hsync_n};
            vs_d  <= {vs_d[PIPE_DEPTH-2:0], scan.vsync_n};
        end
    end

    // Output register, sync leaves together with its colour
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            color   <= '0;
            hsync_n <= 1'b1;
            vsync_n <= 1'b1;
        end else if (dot_en) begin
            if (act_d[PIPE_DEPTH-1] && render_en) begin
                color <= mem.pal_data;
            end else begin
                color <= '0;  // Blank outside the picture
            end
            hsync_n <= hs_d[PIPE_DEPTH-1];
            vsync_n <= vs_d[PIPE_DEPTH-1];
        end
    end

endmodule

// ==== rtl/clock_div.sv ====
module clock_div #(
    parameter int CLK_DIV = 4
) (
    input  logic clk,
    input  logic rst_n,
    output logic dot_en
);

    localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CW-1:0] cnt;

    // Last count of the cycle marks the dot
    assign dot_en = (cnt == CW'(CLK_DIV - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (dot_en) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== rtl/ppu.sv ====
module ppu import ppu_pkg::*; #(
    parameter int CLK_DIV = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cpu_we,
    input  logic [13:0] cpu_addr,
    input  logic [7:0]  cpu_wdata,
    output logic        vblank,   // Interrupt request to the CPU
    output logic        vsync_n,
    output logic        hsync_n,
    output logic [2:0]  vga_r,
    output logic [2:0]  vga_g,
    output logic [1:0]  vga_b
);

    logic       dot_en;
    logic       nt_sel;
    logic       pt_sel;
    logic [1:0] bg_pal;
    logic       render_en;
    logic       nmi_en;
    color_t     color;

    scan_if       scan ();
    render_mem_if rmem ();

    clock_div #(.CLK_DIV(CLK_DIV)) u_clock_div (
        .clk,
        .rst_n,
        .dot_en
    );

    ppu_timing u_timing (
        .clk,
        .rst_n,
        .dot_en,
        .nmi_en,
        .scan   (scan.timing),
        .vblank
    );

    ppu_mem u_mem (
        .clk,
        .rst_n,
        .dot_en,
        .cpu_we,
        .cpu_addr  (cpu_addr_t'(cpu_addr)),
        .cpu_wdata (byte_t'(cpu_wdata)),
        .mem       (rmem.mem),
        .nt_sel,
        .pt_sel,
        .bg_pal,
        .render_en,
        .nmi_en
    );

    bg_pixel u_bg_pixel (
        .clk,
        .rst_n,
        .dot_en,
        .scan   (scan.pixel),
        .mem    (rmem.fetch),
        .nt_sel,
        .pt_sel,
        .bg_pal,
        .render_en,
        .color,
        .hsync_n,
        .vsync_n
    );

    // RGB332 onto the VGA pins
    assign vga_r = color[7:5];
    assign vga_g = color[4:2];
    assign vga_b = color[1:0];

endmodule

// ==== rtl/ppu_mem.sv ====
module ppu_mem import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       dot_en,
    input  logic       cpu_we,
    input  cpu_addr_t  cpu_addr,
    input  byte_t      cpu_wdata,
    render_mem_if.mem  mem,
    output logic       nt_sel,
    output logic       pt_sel,
    output logic [1:0] bg_pal,
    output logic       render_en,
    output logic       nmi_en
);

    byte_t chr_ram  [2**$bits(chr_addr_t)];
    byte_t vram     [2**$bits(vram_addr_t)];
    byte_t pal_ram  [2**$bits(pal_addr_t)];
    byte_t ctrl;

    logic chr_we;
    logic vram_we;
    logic pal_we;
    logic ctrl_we;

    // Region decode, anything else falls through untouched
    assign chr_we  = cpu_we && (cpu_addr[13] == CHR_BASE[13]);
    assign vram_we = cpu_we && (cpu_addr[13:11] == VRAM_BASE[13:11]);
    assign ctrl_we = cpu_we && (cpu_addr == CTRL_ADDR);
    assign pal_we  = cpu_we && (cpu_addr[13:5] == PAL_BASE[13:5]);

    // Pattern memory, one read port per bit plane
    always_ff @(posedge clk) begin
        if (chr_we) begin
            chr_ram[chr_addr_t'(cpu_addr)] <= cpu_wdata;
        end
        if (dot_en) begin
            mem.chr_data0 <= chr_ram[mem.chr_addr0];
            mem.chr_data1 <= chr_ram[mem.chr_addr1];
        end
    end

    always_ff @(posedge clk) begin
        if (vram_we) begin
            vram[vram_addr_t'(cpu_addr)] <= cpu_wdata;
        end
        if (dot_en) begin
            mem.vram_data <= vram[mem.vram_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[pal_addr_t'(cpu_addr)] <= cpu_wdata;  // Low five bits
        end
        if (dot_en) begin
            mem.pal_data <= pal_ram[mem.pal_addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;  // Rendering and interrupt off
        end else if (ctrl_we) begin
            ctrl <= cpu_wdata;
        end
    end

    assign nt_sel    = ctrl[CTRL_NT];
    assign pt_sel    = ctrl[CTRL_PT];
    assign bg_pal    = ctrl[CTRL_PAL +: 2];
    assign render_en = ctrl[CTRL_REN];
    assign nmi_en    = ctrl[CTRL_NMI];

endmodule

// ==== rtl/ppu_pkg.sv ====
package ppu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [13:0] cpu_addr_t;
    typedef logic [12:0] chr_addr_t;   // {pt_sel, tile, plane, fine row}
    typedef logic [10:0] vram_addr_t;  // {nt_sel, tile row, tile col}
    typedef logic [4:0]  pal_addr_t;
    typedef logic [8:0]  coord_t;
    typedef logic [7:0]  color_t;      // RGB332

    typedef enum logic [1:0] {
        PRE_SL,
        VIS_SL,
        POST_SL,
        VBLANK_SL
    } vs_state_t;

    // Raster geometry in dots and rows
    localparam coord_t H_TOTAL      = 9'd341;
    localparam coord_t V_TOTAL      = 9'd262;
    localparam coord_t H_VISIBLE    = 9'd256;
    localparam coord_t V_VISIBLE    = 9'd240;
    localparam coord_t HSYNC_FIRST  = 9'd280;
    localparam coord_t HSYNC_LAST   = 9'd303;
    localparam coord_t VSYNC_FIRST  = 9'd245;
    localparam coord_t VSYNC_LAST   = 9'd247;
    localparam coord_t VBLANK_FIRST = 9'd241;
    localparam coord_t VBLANK_LAST  = 9'd260;

    localparam int PIPE_DEPTH = 3;  // Dots from position to colour

    // CPU address map
    localparam cpu_addr_t CHR_BASE  = 14'h0000;
    localparam cpu_addr_t VRAM_BASE = 14'h2000;
    localparam cpu_addr_t CTRL_ADDR = 14'h3000;
    localparam cpu_addr_t PAL_BASE  = 14'h3F00;

    // Control register fields
    localparam int CTRL_NT  = 0;
    localparam int CTRL_PT  = 1;
    localparam int CTRL_PAL = 2;  // Low bit of the 2-bit palette field
    localparam int CTRL_REN = 4;
    localparam int CTRL_NMI = 7;

endpackage

// ==== rtl/ppu_timing.sv ====
module ppu_timing import ppu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   dot_en,
    input  logic   nmi_en,
    scan_if.timing scan,
    output logic   vblank
);

    coord_t    row;
    coord_t    col;
    logic      line_end;
    vs_state_t vs_state;
    vs_state_t vs_next;
    logic      vblank_flag;

    assign line_end = (col == coord_t'(H_TOTAL - 1));

    // Raster position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row <= '0;
            col <= '0;
        end else if (dot_en) begin
            if (line_end) begin
                col <= '0;
                if (row == coord_t'(V_TOTAL - 1)) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // Vertical FSM, changes only at the end of a line
    always_comb begin
        vs_next = vs_state;
        if (line_end) begin
            case (vs_state)
                PRE_SL: vs_next = VIS_SL;
                VIS_SL: begin
                    if (row == coord_t'(V_VISIBLE - 1)) begin
                        vs_next = POST_SL;
                    end
                end
                POST_SL: begin
                    if (row == coord_t'(VBLANK_FIRST - 1)) begin
                        vs_next = VBLANK_SL;
                    end
                end
                VBLANK_SL: begin
                    if (row == VBLANK_LAST) begin
                        vs_next = PRE_SL;
                    end
                end
                default: vs_next = PRE_SL;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vs_state <= VIS_SL;  // Row 0 is the first visible line
        end else if (dot_en) begin
            vs_state <= vs_next;
        end
    end

    assign vblank_flag = (vs_state == VBLANK_SL);
    assign vblank      = vblank_flag && nmi_en;  // Interrupt to the CPU

    assign scan.row     = row;
    assign scan.col     = col;
    assign scan.active  = (row < V_VISIBLE) && (col < H_VISIBLE);
    assign scan.hsync_n = !((col >= HSYNC_FIRST) && (col <= HSYNC_LAST));
    assign scan.vsync_n = !((row >= VSYNC_FIRST) && (row <= VSYNC_LAST));

endmodule

// ==== rtl/render_mem_if.sv ====
interface render_mem_if import ppu_pkg::*; ();

    vram_addr_t vram_addr;
    byte_t      vram_data;
    chr_addr_t  chr_addr0;  // Plane 0
    chr_addr_t  chr_addr1;  // Plane 1
    byte_t      chr_data0;
    byte_t      chr_data1;
    pal_addr_t  pal_addr;
    byte_t      pal_data;

    // Addresses are sampled by the memory read registers on the dot enable
    modport fetch (
        output vram_addr,
        output chr_addr0,
        output chr_addr1,
        output pal_addr,
        input  vram_data,
        input  chr_data0,
        input  chr_data1,
        input  pal_data
    );

    modport mem (
        input  vram_addr,
        input  chr_addr0,
        input  chr_addr1,
        input  pal_addr,
        output vram_data,
        output chr_data0,
        output chr_data1,
        output pal_data
    );

endinterface

// ==== rtl/scan_if.sv ====
interface scan_if import ppu_pkg::*; ();

    coord_t row;
    coord_t col;
    logic   active;   // Inside the 256 x 240 picture
    logic   hsync_n;  // Not yet delayed to the pixel output
    logic   vsync_n;

    modport timing (
        output row,
        output col,
        output active,
        output hsync_n,
        output vsync_n
    );

    modport pixel (
        input row,
        input col,
        input active,
        input hsync_n,
        input vsync_n
    );

endinterface
